// ==== uart_pkg.sv ====
package uart_pkg;

    localparam int apb_addr_w = 32;
    localparam int apb_data_w = 32;
    localparam int data_w     = 8;   // widest character
    localparam int div_w      = 16;  // {dlm, dll}

    // apb request, master to slave
    typedef struct packed {
        logic [apb_addr_w-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_data_w-1:0] pwdata;
    } apb_req_t;

    // apb response, slave to master
    typedef struct packed {
        logic [apb_data_w-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // word index from paddr[4:2], holes at 2, 4 and 6 read zero
    typedef enum logic [2:0] {
        idx_rbr_thr = 3'd0,  // dll when dlab
        idx_ier_dlm = 3'd1,  // dlm when dlab
        idx_lcr     = 3'd3,
        idx_lsr     = 3'd5,
        idx_scr     = 3'd7
    } reg_idx_e;

    // decoded lcr fields
    typedef struct packed {
        logic [3:0] data_bits;    // 5 to 8
        logic       two_stop;
        logic       parity_en;
        logic       even_parity;
    } line_ctrl_t;

    // one received character with its error flags
    typedef struct packed {
        logic [data_w-1:0] data;
        logic              parity_err;
        logic              frame_err;
    } rx_frame_t;

endpackage

// ==== apb_uart_regs.sv ====
`timescale 1ns/10ps

module apb_uart_regs import uart_pkg::*; (
    input  logic              apb_slave,
    input  logic              rst,
    input  apb_req_t          apb_req,
    output apb_rsp_t          apb_rsp,
    output logic              push,
    output logic [data_w-1:0] push_data,
    input  logic              fifo_full,
    input  logic              fifo_empty,
    input  logic              tx_idle,
    output line_ctrl_t        line_ctrl,
    output logic [div_w-1:0]  divisor,
    input  logic              rx_req,
    input  rx_frame_t         rx_frame,
    output logic              rx_ack
);

    logic              access;
    logic              wr_en;
    logic              rd_en;
    reg_idx_e          idx;
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] rd_byte;
    logic              dlab;
    logic              rbr_rd;
    logic              lsr_rd;

    logic [data_w-1:0] lcr;
    logic [data_w-1:0] dll;
    logic [data_w-1:0] dlm;
    logic [data_w-1:0] scr;
    logic [data_w-1:0] rbr;
    logic [data_w-1:0] lsr;
    logic              data_ready;
    logic              overrun;
    logic              parity_err;
    logic              frame_err;

    assign access = apb_req.psel && apb_req.penable;  // no wait states
    assign wr_en  = access && apb_req.pwrite;
    assign rd_en  = access && !apb_req.pwrite;
    assign idx    = reg_idx_e'(apb_req.paddr[4:2]);
    assign wdata  = apb_req.pwdata[data_w-1:0];
    assign dlab   = lcr[7];
    assign rbr_rd = rd_en && (idx == idx_rbr_thr) && !dlab;
    assign lsr_rd = rd_en && (idx == idx_lsr);

    // full fifo drops the write
    assign push      = wr_en && (idx == idx_rbr_thr) && !dlab && !fifo_full;
    assign push_data = wdata;

    assign line_ctrl.data_bits   = 4'd5 + {2'b00, lcr[1:0]};
    assign line_ctrl.two_stop    = lcr[2];
    assign line_ctrl.parity_en   = lcr[3];
    assign line_ctrl.even_parity = lcr[4];
    assign divisor               = {dlm, dll};

    assign lsr = {1'b0, fifo_empty && tx_idle, fifo_empty, 1'b0,
                  frame_err, parity_err, overrun, data_ready};

    always_comb begin
        case (idx)
            idx_rbr_thr: rd_byte = dlab ? dll : rbr;
            idx_ier_dlm: rd_byte = dlab ? dlm : '0;  // ier not implemented
            idx_lcr:     rd_byte = lcr;
            idx_lsr:     rd_byte = lsr;
            idx_scr:     rd_byte = scr;
            default:     rd_byte = '0;
        endcase
    end

    assign apb_rsp.prdata  = {{(apb_data_w - data_w){1'b0}}, rd_byte};
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = 1'b0;

    always_ff @(posedge apb_slave) begin
        if (rst) begin
            lcr        <= '0;
            dll        <= 8'h01;
            dlm        <= '0;
            scr        <= '0;
            rbr        <= '0;
            data_ready <= 1'b0;
            overrun    <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            rx_ack     <= 1'b0;
        end else begin
            if (wr_en) begin
                case (idx)
                    idx_rbr_thr: begin
                        if (dlab) begin
                            dll <= wdata;
                        end
                    end
                    idx_ier_dlm: begin
                        if (dlab) begin
                            dlm <= wdata;
                        end
                    end
                    idx_lcr: lcr <= wdata;
                    idx_scr: scr <= wdata;
                    default: ;
                endcase
            end
            if (rbr_rd) begin
                data_ready <= 1'b0;
            end
            if (lsr_rd) begin  // error flags clear on read
                overrun    <= 1'b0;
                parity_err <= 1'b0;
                frame_err  <= 1'b0;
            end
            // new frame wins over a clear in the same cycle
            if (rx_req && !rx_ack) begin
                rbr        <= rx_frame.data;
                data_ready <= 1'b1;
                rx_ack     <= 1'b1;
                if (data_ready && !rbr_rd) begin
                    overrun <= 1'b1;  // old byte lost
                end
                if (rx_frame.parity_err) begin
                    parity_err <= 1'b1;
                end
                if (rx_frame.frame_err) begin
                    frame_err <= 1'b1;
                end
            end else if (!rx_req && rx_ack) begin
                rx_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== uart_tx_fifo.sv ====
`timescale 1ns/10ps

module uart_tx_fifo import uart_pkg::*; #(
    parameter int fifo_depth = 8
) (
    input  logic              apb_slave,
    input  logic              rst,
    input  logic              push,
    input  logic [data_w-1:0] push_data,
    output logic              full,
    output logic              empty,
    output logic              tx_req,
    output logic [data_w-1:0] tx_byte,
    input  logic              tx_ack
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    logic [data_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign full    = (count == cnt_w'(fifo_depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = tx_req && tx_ack;  // head consumed by tx
    assign tx_byte = mem[rd_ptr];

    always_ff @(posedge apb_slave) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge apb_slave) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            tx_req <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
            // four-phase: drop on ack, rise again only once ack is low
            if (do_pop) begin
                tx_req <= 1'b0;
            end else if (!tx_req && !tx_ack && !empty) begin
                tx_req <= 1'b1;
            end
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import uart_pkg::*; (
    input  logic              apb_slave,
    input  logic              rst,
    input  logic              tx_req,
    input  logic [data_w-1:0] tx_byte,
    output logic              tx_ack,
    input  line_ctrl_t        line_ctrl,
    input  logic [div_w-1:0]  divisor,
    output logic              tx_idle,
    output logic              tx
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } tx_state_e;

    tx_state_e         state;
    logic [div_w-1:0]  div_eff;
    logic [div_w+1:0]  bit_len;
    logic [div_w+1:0]  cnt;
    logic              bit_end;
    logic              accept;
    logic [data_w-1:0] data_mask;
    logic [data_w-1:0] shreg;
    logic [2:0]        bit_idx;
    logic              par_bit;
    logic              second_stop;
    line_ctrl_t        lc;
    logic              line_bit;

    assign div_eff   = (divisor == '0) ? div_w'(1) : divisor;
    assign bit_len   = {div_eff, 2'b00};  // 4 cycles per divisor unit
    assign bit_end   = (cnt == bit_len - 1'b1);
    assign accept    = (state == st_idle) && tx_req && !tx_ack;
    assign data_mask = 8'hff >> (4'd8 - line_ctrl.data_bits);
    assign tx_idle   = (state == st_idle);

    always_comb begin
        case (state)
            st_start:  line_bit = 1'b0;
            st_data:   line_bit = shreg[0];  // lsb first
            st_parity: line_bit = par_bit;
            default:   line_bit = 1'b1;
        endcase
    end

    // frame payload, loaded when a byte is taken
    always_ff @(posedge apb_slave) begin
        if (accept) begin
            shreg   <= tx_byte & data_mask;
            lc      <= line_ctrl;
            par_bit <= ^(tx_byte & data_mask) ^ ~line_ctrl.even_parity;
        end else if (state == st_data && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge apb_slave) begin
        if (rst) begin
            state       <= st_idle;
            tx_ack      <= 1'b0;
            tx          <= 1'b1;
            cnt         <= '0;
            bit_idx     <= '0;
            second_stop <= 1'b0;
        end else begin
            tx  <= line_bit;
            cnt <= (state == st_idle || bit_end) ? '0 : cnt + 1'b1;
            if (tx_ack && !tx_req) begin
                tx_ack <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (accept) begin
                        tx_ack <= 1'b1;
                        state  <= st_start;
                    end
                end
                st_start: begin
                    bit_idx     <= '0;
                    second_stop <= 1'b0;
                    if (bit_end) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if ({1'b0, bit_idx} == lc.data_bits - 4'd1) begin
                            state <= lc.parity_en ? st_parity : st_stop;
                        end
                    end
                end
                st_parity: begin
                    if (bit_end) begin
                        state <= st_stop;
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        if (lc.two_stop && !second_stop) begin
                            second_stop <= 1'b1;
                        end else begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx import uart_pkg::*; (
    input  logic             apb_slave,
    input  logic             rst,
    input  logic             rx,
    input  line_ctrl_t       line_ctrl,
    input  logic [div_w-1:0] divisor,
    output logic             rx_req,
    output rx_frame_t        rx_frame,
    input  logic             rx_ack
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop,
        st_handoff
    } rx_state_e;

    rx_state_e         state;
    logic              rx_meta;
    logic              rx_sync;
    logic [div_w-1:0]  div_eff;
    logic [div_w+1:0]  cnt;
    logic [div_w+1:0]  target;
    logic              hit;
    logic [data_w-1:0] data;
    logic [2:0]        bit_idx;
    logic              second_stop;
    logic              par_exp;
    logic              par_err;
    logic              frm_err;

    assign div_eff = (divisor == '0) ? div_w'(1) : divisor;
    // half a bit to the middle of start, then a full bit each
    assign target  = (state == st_start) ? {1'b0, div_eff, 1'b0} - 1'b1
                                         : {div_eff, 2'b00} - 1'b1;
    assign hit     = (cnt == target);
    assign par_exp = ^data ^ ~line_ctrl.even_parity;

    assign rx_frame.data       = data;
    assign rx_frame.parity_err = par_err;
    assign rx_frame.frame_err  = frm_err;

    always_ff @(posedge apb_slave) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // sampled frame, held through the hand-off
    always_ff @(posedge apb_slave) begin
        if (state == st_start && hit) begin
            data    <= '0;
            par_err <= 1'b0;
            frm_err <= 1'b0;
        end
        if (state == st_data && hit) begin
            data[bit_idx] <= rx_sync;
        end
        if (state == st_parity && hit) begin
            par_err <= (rx_sync != par_exp);
        end
        if (state == st_stop && hit && !rx_sync) begin
            frm_err <= 1'b1;
        end
    end

    always_ff @(posedge apb_slave) begin
        if (rst) begin
            state       <= st_idle;
            cnt         <= '0;
            bit_idx     <= '0;
            second_stop <= 1'b0;
            rx_req      <= 1'b0;
        end else begin
            cnt <= (state == st_idle || state == st_handoff || hit) ? '0 : cnt + 1'b1;
            case (state)
                st_idle: begin
                    if (!rx_sync) begin  // line fell from idle high
                        state <= st_start;
                    end
                end
                st_start: begin
                    bit_idx     <= '0;
                    second_stop <= 1'b0;
                    if (hit) begin
                        state <= rx_sync ? st_idle : st_data;  // glitch rejected
                    end
                end
                st_data: begin
                    if (hit) begin
                        bit_idx <= bit_idx + 1'b1;
                        if ({1'b0, bit_idx} == line_ctrl.data_bits - 4'd1) begin
                            state <= line_ctrl.parity_en ? st_parity : st_stop;
                        end
                    end
                end
                st_parity: begin
                    if (hit) begin
                        state <= st_stop;
                    end
                end
                st_stop: begin
                    if (hit) begin
                        if (line_ctrl.two_stop && !second_stop) begin
                            second_stop <= 1'b1;
                        end else if (!rx_ack) begin
                            rx_req <= 1'b1;
                            state  <= st_handoff;
                        end
                    end
                end
                st_handoff: begin
                    if (rx_ack) begin
                        rx_req <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/10ps

module uart_top import uart_pkg::*; #(
    parameter int fifo_depth = 8
) (
    input  logic     apb_slave,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     rx,
    output logic     tx
);

    logic              push;
    logic [data_w-1:0] push_data;
    logic              fifo_full;
    logic              fifo_empty;
    logic              tx_req;
    logic              tx_ack;
    logic [data_w-1:0] tx_byte;
    logic              tx_idle;
    line_ctrl_t        line_ctrl;
    logic [div_w-1:0]  divisor;
    logic              rx_req;
    logic              rx_ack;
    rx_frame_t         rx_frame;

    apb_uart_regs u_regs (
        .apb_slave  (apb_slave),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .push       (push),
        .push_data  (push_data),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .tx_idle    (tx_idle),
        .line_ctrl  (line_ctrl),
        .divisor    (divisor),
        .rx_req     (rx_req),
        .rx_frame   (rx_frame),
        .rx_ack     (rx_ack)
    );

    uart_tx_fifo #(
        .fifo_depth (fifo_depth)
    ) u_tx_fifo (
        .apb_slave (apb_slave),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .full      (fifo_full),
        .empty     (fifo_empty),
        .tx_req    (tx_req),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack)
    );

    uart_tx u_tx (
        .apb_slave (apb_slave),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack),
        .line_ctrl (line_ctrl),
        .divisor   (divisor),
        .tx_idle   (tx_idle),
        .tx        (tx)
    );

    uart_rx u_rx (
        .apb_slave (apb_slave),
        .rst       (rst),
        .rx        (rx),
        .line_ctrl (line_ctrl),
        .divisor   (divisor),
        .rx_req    (rx_req),
        .rx_frame  (rx_frame),
        .rx_ack    (rx_ack)
    );

endmodule

// ==== uart_props.sv ====
`timescale 1ns/10ps

module uart_props import uart_pkg::*; (
    input logic      apb_slave,
    input logic      rst,
    input logic      tx_req,
    input logic      tx_ack,
    input logic      tx_idle,
    input logic      tx,
    input logic      rx_req,
    input logic      rx_ack,
    input rx_frame_t rx_frame
);

    // fifo keeps offering the head byte until tx takes it
    a_tx_req_hold: assert property (@(posedge apb_slave) disable iff (rst)
        (tx_req && !tx_ack) |=> tx_req)
        else $error("tx_req dropped before tx_ack");

    a_tx_ack_rise: assert property (@(posedge apb_slave) disable iff (rst)
        $rose(tx_ack) |-> tx_req)
        else $error("tx_ack rose without tx_req");

    a_rx_req_hold: assert property (@(posedge apb_slave) disable iff (rst)
        (rx_req && !rx_ack) |=> (rx_req && $stable(rx_frame)))
        else $error("rx_req or rx_frame changed before rx_ack");

    a_tx_idle_high: assert property (@(posedge apb_slave) disable iff (rst)
        tx_idle |-> tx)
        else $error("tx line low while transmitter idle");

endmodule

// ==== tb_uart_top.sv ====
`timescale 1ns/10ps

module tb_uart_top import uart_pkg::*; ();

    localparam int fifo_depth = 8;
    localparam int poll_limit = 1000;  // lsr reads per wait

    typedef logic [8*16-1:0] name_t;

    logic       apb_slave;
    logic       rst;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       tx;
    logic       rx_drv;
    logic       loopback;  // tx fed back to rx
    logic       rx_line;
    logic [7:0] lcr_sh;
    logic [7:0] dll_sh;
    logic [7:0] dlm_sh;
    int         checks;
    int         mismatches;
    int         other_errs;
    name_t      cur_name;  // record being run

    assign rx_line = loopback ? tx : rx_drv;

    uart_top #(
        .fifo_depth (fifo_depth)
    ) u_uart_top (
        .apb_slave (apb_slave),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .rx        (rx_line),
        .tx        (tx)
    );

    bind uart_top uart_props u_props (
        .apb_slave (apb_slave),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .tx_idle   (tx_idle),
        .tx        (tx),
        .rx_req    (rx_req),
        .rx_ack    (rx_ack),
        .rx_frame  (rx_frame)
    );

    initial begin
        apb_slave = 1'b0;
        forever #2 apb_slave = ~apb_slave;
    end

    function automatic int bit_cycles();
        logic [15:0] div;
        div = {dlm_sh, dll_sh};
        if (div == 16'h0) begin
            div = 16'h1;
        end
        return 4 * div;
    endfunction

    // value of the parity bit for the active data bits
    function automatic logic parity_of(input logic [7:0] data, input int nbits,
                                       input logic even);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < nbits; i++) begin
            ones += data[i];
        end
        return even ? (ones % 2 == 1) : (ones % 2 == 0);
    endfunction

    task automatic check_byte(input name_t name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %0s expected %02h actual %02h", name, exp, act);
            mismatches++;
        end
    endtask

    // no wait states and no slave errors
    task automatic check_rsp();
        checks++;
        if (apb_rsp.pready !== 1'b1 || apb_rsp.pslverr !== 1'b0) begin
            $display("FAILED %0s expected pready 1 pslverr 0 actual pready %0b pslverr %0b",
                     cur_name, apb_rsp.pready, apb_rsp.pslverr);
            mismatches++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
        apb_req.paddr   = apb_addr_w'(addr);
        apb_req.pwdata  = apb_data_w'(data);
        apb_req.pwrite  = 1'b1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge apb_slave);
        #1;
        apb_req.penable = 1'b1;
        #1;
        check_rsp();
        @(posedge apb_slave);  // write lands here
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        if (addr == 8'h0c) begin
            lcr_sh = data;
        end else if (lcr_sh[7] && addr == 8'h00) begin
            dll_sh = data;
        end else if (lcr_sh[7] && addr == 8'h04) begin
            dlm_sh = data;
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [7:0] data);
        apb_req.paddr   = apb_addr_w'(addr);
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge apb_slave);
        #1;
        apb_req.penable = 1'b1;
        #1;
        data = apb_rsp.prdata[7:0];  // mid access phase
        check_rsp();
        @(posedge apb_slave);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic wait_lsr(input name_t name, input logic [7:0] mask, output logic [7:0] lsr);
        int tries;
        tries = 0;
        lsr   = 8'h00;
        while ((lsr & mask) == 8'h00 && tries < poll_limit) begin
            apb_read(8'h14, lsr);
            tries++;
        end
        if ((lsr & mask) == 8'h00) begin
            $display("%0s: timed out waiting for LSR bits %02h", name, mask);
            other_errs++;
        end
    endtask

    task automatic hold_line(input logic level);
        int n;
        n      = bit_cycles();
        rx_drv = level;
        repeat (n) begin
            @(posedge apb_slave);
            #1;
        end
    endtask

    // kind 1 flips parity and kind 2 pulls the stop bit low
    task automatic inject_frame(input logic [7:0] data, input logic [7:0] kind);
        int   nbits;
        int   i;
        logic par;
        nbits    = 5 + lcr_sh[1:0];
        par      = parity_of(data, nbits, lcr_sh[4]);
        loopback = 1'b0;
        hold_line(1'b0);
        for (i = 0; i < nbits; i++) begin
            hold_line(data[i]);
        end
        if (lcr_sh[3]) begin
            hold_line((kind == 8'h01) ? ~par : par);
        end
        hold_line(kind != 8'h02);
        if (lcr_sh[2]) begin
            hold_line(1'b1);
        end
        hold_line(1'b1);  // idle gap for the hand-off
        loopback = 1'b1;
    endtask

    task automatic send_byte(input name_t name, input logic [7:0] data, input logic [7:0] exp);
        logic [7:0] lsr;
        logic [7:0] rbr;
        apb_write(8'h00, data);
        wait_lsr(name, 8'h01, lsr);
        check_byte(name, 8'h00, lsr & 8'h0e);  // no error flags
        apb_read(8'h00, rbr);
        check_byte(name, exp, rbr);
        wait_lsr(name, 8'h40, lsr);
    endtask

    task automatic fifo_burst(input name_t name);
        logic [7:0] sent [$];
        logic [7:0] b;
        logic [7:0] lsr;
        logic [7:0] rbr;
        int         i;
        // tx takes the first byte at once, so depth + 1 writes fill the FIFO
        for (i = 0; i <= fifo_depth; i++) begin
            b = 8'($urandom);
            sent.push_back(b);
            apb_write(8'h00, b);
        end
        b = 8'($urandom);
        apb_write(8'h00, b);  // dropped by the full FIFO
        for (i = 0; i < sent.size(); i++) begin
            wait_lsr(name, 8'h01, lsr);
            apb_read(8'h00, rbr);
            check_byte(name, sent[i], rbr);
        end
        wait_lsr(name, 8'h40, lsr);
        apb_read(8'h14, lsr);
        check_byte(name, 8'h60, lsr);  // extra byte never arrives
    endtask

    task automatic run_record(input name_t name, input name_t op, input logic [7:0] addr,
                              input logic [7:0] data, input logic [7:0] exp);
        logic [7:0] rd;
        cur_name = name;
        if (op == "wr") begin
            apb_write(addr, data);
        end else if (op == "rd") begin
            apb_read(addr, rd);
            check_byte(name, exp, rd);
        end else if (op == "send") begin
            send_byte(name, data, exp);
        end else if (op == "inj") begin
            inject_frame(data, addr);
        end else if (op == "burst") begin
            fifo_burst(name);
        end else begin
            $display("%0s: unknown operation %0s in the golden file", name, op);
            other_errs++;
        end
    endtask

    initial begin
        int              fd;
        int              n;
        int              seed;
        logic [8*96-1:0] line;
        name_t           name;
        name_t           op;
        logic [7:0]      addr;
        logic [7:0]      data;
        logic [7:0]      exp;
        seed       = $urandom(32'h4587);
        checks     = 0;
        mismatches = 0;
        other_errs = 0;
        cur_name   = '0;
        apb_req    = '0;
        rx_drv     = 1'b1;
        loopback   = 1'b1;
        lcr_sh     = 8'h00;
        dll_sh     = 8'h01;
        dlm_sh     = 8'h00;
        rst        = 1'b1;
        repeat (4) begin
            @(posedge apb_slave);
        end
        #1;
        rst = 1'b0;
        fd = $fopen("uart_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open uart_golden.txt");
            other_errs++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, exp);
                if (n == 5) begin  // comment lines parse short
                    run_record(name, op, addr, data, exp);
                end
            end
            $fclose(fd);
        end
        if (checks == 0) begin
            $display("no checks ran");
            other_errs++;
        end
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== uart_top.f ====
uart_pkg.sv
apb_uart_regs.sv
uart_tx_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_props.sv
tb_uart_top.sv

// ==== Bender.yml ====
package:
  name: apb_uart

sources:
  - uart_pkg.sv
  - apb_uart_regs.sv
  - uart_tx_fifo.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_top.sv
  - target: test
    files:
      - uart_props.sv
      - tb_uart_top.sv

// ==== uart_golden.txt ====
# columns: test name, operation, address, write data, expected value (hex)
# ops: wr write, rd read and compare, send loop back through THR and RBR, inj drive rx
#   (inj address 0 clean, 1 bad parity, 2 low stop), burst random FIFO burst
lsr_reset rd 14 00 60
scr_rw wr 1c a7 00
scr_rw rd 1c 00 a7
lcr_rw wr 0c 1f 00
lcr_rw rd 0c 00 1f
dlab_on wr 0c 83 00
dlm_rw wr 04 5a 00
dlm_rw rd 04 00 5a
dlm_clr wr 04 00 00
dll_rw wr 00 02 00
dll_rw rd 00 00 02
fmt_8n1 wr 0c 03 00
loop_8n1 send 00 a5 a5
loop_8n1 send 00 3c 3c
lsr_idle rd 14 00 60
fmt_5n1 wr 0c 00 00
loop_5n1 send 00 ff 1f
fmt_6e1 wr 0c 19 00
loop_6e1 send 00 a5 25
fmt_7o2 wr 0c 0e 00
loop_7o2 send 00 c3 43
fmt_8n1b wr 0c 03 00
fifo_burst burst 00 00 00
fmt_8e1 wr 0c 1b 00
par_err inj 01 5a 00
par_err rd 14 00 65
par_err rd 14 00 61
par_err rd 00 00 5a
frm_err inj 02 3c 00
frm_err rd 14 00 69
frm_err rd 14 00 61
frm_err rd 00 00 3c
ovr_first inj 00 11 00
ovr_second inj 00 22 00
overrun rd 14 00 63
overrun rd 14 00 61
overrun rd 00 00 22
